// ==== verif/touch_stim.txt ====
// Per row: X raw 0..3, Y raw 0..3, Z raw 0..3, then expected X, Y, Z and pen
// All values in hex, one frame per row
// X below minimum, Y mid range, pen down
050 060 070 080 800 802 804 806 400 400 400 400 000 6D7 400 1
// X and Y at the top of the range
FF0 FF4 FF8 FFC FFF FFF FFF FFF 2A0 2A1 2A2 2A3 F60 ED3 2A1 1
// Mid range, Z just above the threshold
7D0 7D1 7D2 7D3 5A0 5A4 5A8 5AC 101 101 101 101 73B 47A 101 1
// Y below minimum, Z at the threshold so pen up
300 300 300 300 100 110 120 130 0FF 100 100 101 26A 000 100 0

// ==== project.f ====
design/touch_pkg.sv
design/touch_serial_link.sv
design/touch_scan_engine.sv
design/touch_axil_regs.sv
design/touchpad_controller.sv
verif/tb_clock.sv
verif/touch_adc_model.sv
verif/tb_touchpad_controller.sv

// ==== Makefile ====
# Verilator flow for the touchpad controller
TOP ?= tb_touchpad_controller
SEED ?= 1
VERILATOR ?= verilator
LOG ?= sim.log
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert --timescale 1ns/100ps

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary -Wno-fatal $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)

# Result is taken from the log, not from the exit code
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	@if grep -qx 'Test OK' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/tb_touchpad_controller.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_touchpad_controller;
	import touch_pkg::*;

	localparam int HS_LIMIT = 50;
	localparam int FRAME_POLLS = 4000;
	localparam int FRAME_CYCLES = 40000;
	localparam int STIM_ROWS = 4;
	localparam int CMDS_PER_FRAME = 12;

	logic cclk;
	logic rstb;
	logic touch_clk;
	logic touch_csb;
	logic data_out;
	logic data_in;
	logic touch_busy;
	logic hold_busy;
	logic [AXIL_ADDR_BITS-1:0] axil_awaddr;
	logic axil_awvalid;
	logic axil_awready;
	logic [31:0] axil_wdata;
	logic [3:0] axil_wstrb;
	logic axil_wvalid;
	logic axil_wready;
	logic [1:0] axil_bresp;
	logic axil_bvalid;
	logic axil_bready;
	logic [AXIL_ADDR_BITS-1:0] axil_araddr;
	logic axil_arvalid;
	logic axil_arready;
	logic [31:0] axil_rdata;
	logic [1:0] axil_rresp;
	logic axil_rvalid;
	logic axil_rready;

	logic [RESULT_BITS-1:0] stim [0:STIM_ROWS*16-1];
	int error_count;
	int errors_before;
	int tests_run;
	int tests_failed;
	int clk_edges = 0;
	int i;
	int n;
	int row;
	logic [31:0] rd_data;
	logic [31:0] held_data;
	logic [31:0] x_before;
	logic [1:0] resp;
	logic [15:0] frames;
	logic [15:0] frames_now;
	logic [2:0] chan;

	tb_clock i_tb_clock (
		.cclk(cclk),
		.rstb(rstb)
	);

	touch_adc_model i_adc_model (
		.touch_clk(touch_clk),
		.touch_csb(touch_csb),
		.data_out(data_out),
		.hold_busy(hold_busy),
		.data_in(data_in),
		.touch_busy(touch_busy)
	);

	touchpad_controller i_touchpad_controller (.*);

	always @(posedge touch_clk) begin
		clk_edges <= clk_edges + 1;
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual,
				expected);
			error_count++;
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timeout at %0t ns while waiting for %s", $time, what);
		$display("Test FAILED");
		$finish;
	endtask

	task automatic write_reg(input logic [AXIL_ADDR_BITS-1:0] addr,
		input logic [31:0] data, output logic [1:0] bresp);
		int cnt;
		@(negedge cclk);
		axil_awaddr = addr;
		axil_wdata = data;
		axil_wstrb = 4'hF;
		axil_awvalid = 1'b1;
		axil_wvalid = 1'b1;
		axil_bready = 1'b1;
		cnt = 0;
		while (!(axil_awready && axil_wready) && cnt < HS_LIMIT) begin
			@(negedge cclk);
			cnt++;
		end
		if (!(axil_awready && axil_wready)) abort_on_timeout("write address and data ready");
		@(negedge cclk);
		axil_awvalid = 1'b0;
		axil_wvalid = 1'b0;
		cnt = 0;
		while (!axil_bvalid && cnt < HS_LIMIT) begin
			@(negedge cclk);
			cnt++;
		end
		if (!axil_bvalid) abort_on_timeout("the write response");
		bresp = axil_bresp;
		@(negedge cclk);
		axil_bready = 1'b0;
	endtask

	task automatic read_reg(input logic [AXIL_ADDR_BITS-1:0] addr,
		output logic [31:0] data, output logic [1:0] rresp);
		int cnt;
		@(negedge cclk);
		axil_araddr = addr;
		axil_arvalid = 1'b1;
		axil_rready = 1'b1;
		cnt = 0;
		while (!axil_arready && cnt < HS_LIMIT) begin
			@(negedge cclk);
			cnt++;
		end
		if (!axil_arready) abort_on_timeout("read address ready");
		@(negedge cclk);
		axil_arvalid = 1'b0;
		cnt = 0;
		while (!axil_rvalid && cnt < HS_LIMIT) begin
			@(negedge cclk);
			cnt++;
		end
		if (!axil_rvalid) abort_on_timeout("read data valid");
		data = axil_rdata;
		rresp = axil_rresp;
		@(negedge cclk);
		axil_rready = 1'b0;
	endtask

	// Poll STATUS until the frame counter moves past prev
	task automatic wait_frame(input logic [15:0] prev, output logic [15:0] now);
		logic [31:0] status;
		logic [1:0] rresp;
		int polls;
		polls = 0;
		read_reg(REG_STATUS, status, rresp);
		while (status[31:16] == prev && polls < FRAME_POLLS) begin
			repeat (8) @(negedge cclk);
			read_reg(REG_STATUS, status, rresp);
			polls++;
		end
		if (status[31:16] == prev) abort_on_timeout("the STATUS frame counter to advance");
		now = status[31:16];
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (error_count == errors_before) begin
			$display("%-20s passed", name);
		end else begin
			tests_failed++;
			$display("%-20s failed with %0d mismatches", name, error_count - errors_before);
		end
		errors_before = error_count;
	endtask

	initial begin
		$readmemh("verif/touch_stim.txt", stim);
		error_count = 0;
		errors_before = 0;
		tests_run = 0;
		tests_failed = 0;
		hold_busy = 1'b0;
		axil_awaddr = '0;
		axil_awvalid = 1'b0;
		axil_wdata = '0;
		axil_wstrb = '0;
		axil_wvalid = 1'b0;
		axil_bready = 1'b0;
		axil_araddr = '0;
		axil_arvalid = 1'b0;
		axil_rready = 1'b0;
		n = 0;
		while (!rstb && n < 20) begin
			@(negedge cclk);
			n++;
		end
		if (!rstb) abort_on_timeout("reset release");

		// Idle after reset
		check_value("touch_csb", 32'(touch_csb), 32'd1);
		check_value("touch_clk", 32'(touch_clk), 32'd0);
		check_value("data_out", 32'(data_out), 32'd0);
		check_value("axil_awready", 32'(axil_awready), 32'd0);
		check_value("axil_wready", 32'(axil_wready), 32'd0);
		check_value("axil_bvalid", 32'(axil_bvalid), 32'd0);
		check_value("axil_arready", 32'(axil_arready), 32'd0);
		check_value("axil_rvalid", 32'(axil_rvalid), 32'd0);
		read_reg(REG_CTRL, rd_data, resp);
		check_value("CTRL", rd_data, 32'd0);
		check_value("axil_rresp", 32'(resp), 32'(RESP_OKAY));
		read_reg(REG_STATUS, rd_data, resp);
		check_value("STATUS frame count", 32'(rd_data[31:16]), 32'd0);
		n = clk_edges;
		repeat (400) @(negedge cclk);
		check_value("touch_clk edges", 32'(clk_edges - n), 32'd0);
		report_test("reset state");

		write_reg(REG_CTRL, 32'd1, resp);
		check_value("axil_bresp", 32'(resp), 32'(RESP_OKAY));
		frames = 16'd0;
		for (row = 0; row < STIM_ROWS; row++) begin
			wait_frame(frames, frames_now);
			check_value("STATUS frame count", 32'(frames_now), 32'(frames) + 32'd1);
			frames = frames_now;
			read_reg(REG_X, rd_data, resp);
			check_value("X", rd_data, 32'(stim[row*16+12]));
			read_reg(REG_Y, rd_data, resp);
			check_value("Y", rd_data, 32'(stim[row*16+13]));
			read_reg(REG_Z, rd_data, resp);
			check_value("Z", rd_data, 32'(stim[row*16+14]));
			read_reg(REG_STATUS, rd_data, resp);
			check_value("STATUS pen", 32'(rd_data[0]), 32'(stim[row*16+15]));
		end
		report_test("frames");

		// Start bit, channel, 12 bit mode, single ended, no power down
		check_value("commands seen", 32'(i_adc_model.cmd_count >= 48), 32'd1);
		for (i = 0; i < 48; i++) begin
			case ((i / 4) % 3)
				0: chan = 3'b101;
				1: chan = 3'b001;
				default: chan = 3'b011;
			endcase
			check_value($sformatf("command byte %0d", i), 32'(i_adc_model.cmd_log[i]),
				32'({1'b1, chan, 1'b0, 1'b1, 2'b00}));
		end
		report_test("command format");

		read_reg(REG_X, x_before, resp);
		write_reg(REG_X, 32'h0000_0123, resp);
		check_value("axil_bresp", 32'(resp), 32'(RESP_SLVERR));
		read_reg(REG_X, rd_data, resp);
		check_value("X", rd_data, x_before);
		read_reg(5'h14, rd_data, resp);
		check_value("axil_rresp", 32'(resp), 32'(RESP_SLVERR));
		check_value("axil_rdata", rd_data, 32'd0);
		report_test("protocol errors");

		// STATUS read held off by rready while the next frame lands
		n = i_adc_model.cmd_count;
		i = 0;
		while ((i_adc_model.cmd_count == n || i_adc_model.cmd_count % CMDS_PER_FRAME != 0)
			&& i < FRAME_CYCLES) begin
			@(negedge cclk);
			i++;
		end
		if (i_adc_model.cmd_count == n || i_adc_model.cmd_count % CMDS_PER_FRAME != 0) begin
			abort_on_timeout("the last command of a frame");
		end
		i = 0;
		while (!touch_csb && i < FRAME_CYCLES) begin
			@(negedge cclk);
			i++;
		end
		if (!touch_csb) abort_on_timeout("the last conversion of a frame to end");
		axil_araddr = REG_STATUS;
		axil_arvalid = 1'b1;
		n = 0;
		while (!axil_arready && n < HS_LIMIT) begin
			@(negedge cclk);
			n++;
		end
		if (!axil_arready) abort_on_timeout("read address ready under back-pressure");
		@(negedge cclk);
		axil_arvalid = 1'b0;
		n = 0;
		while (!axil_rvalid && n < HS_LIMIT) begin
			@(negedge cclk);
			n++;
		end
		if (!axil_rvalid) abort_on_timeout("read data valid under back-pressure");
		held_data = axil_rdata;
		for (i = 0; i < 20; i++) begin
			@(negedge cclk);
			check_value("axil_rvalid", 32'(axil_rvalid), 32'd1);
			check_value("axil_rdata", axil_rdata, held_data);
		end
		axil_rready = 1'b1;
		rd_data = axil_rdata;
		@(negedge cclk);
		axil_rready = 1'b0;
		check_value("axil_rvalid", 32'(axil_rvalid), 32'd0);
		check_value("accepted axil_rdata", rd_data, held_data);
		// Frame finished while the response was held
		read_reg(REG_STATUS, rd_data, resp);
		check_value("STATUS frame count", 32'(rd_data[31:16]), 32'(frames) + 32'd1);
		frames = rd_data[31:16];
		report_test("back-pressure");

		// Hold busy from the start of a fresh frame
		wait_frame(frames, frames_now);
		hold_busy = 1'b1;
		frames = frames_now;
		wait_frame(frames, frames_now);
		read_reg(REG_X, rd_data, resp);
		check_value("X", rd_data, 32'd0);
		read_reg(REG_Y, rd_data, resp);
		check_value("Y", rd_data, 32'd0);
		read_reg(REG_STATUS, rd_data, resp);
		check_value("STATUS pen", 32'(rd_data[0]), 32'd0);
		write_reg(REG_CTRL, 32'd0, resp);
		n = 0;
		while (!touch_csb && n < 4000) begin
			@(negedge cclk);
			n++;
		end
		if (!touch_csb) abort_on_timeout("touch_csb to rise after the scan stop");
		repeat (10) @(negedge cclk);
		read_reg(REG_STATUS, rd_data, resp);
		frames = rd_data[31:16];
		n = clk_edges;
		row = 0;
		for (i = 0; i < 4000; i++) begin
			@(negedge cclk);
			if (!touch_csb) row++;
		end
		check_value("touch_csb low samples", 32'(row), 32'd0);
		check_value("touch_clk edges", 32'(clk_edges - n), 32'd0);
		read_reg(REG_STATUS, rd_data, resp);
		check_value("STATUS frame count", 32'(rd_data[31:16]), 32'(frames));
		report_test("timeout and stop");

		$display("Summary: %0d tests run, %0d failed, %0d mismatches", tests_run,
			tests_failed, error_count);
		if (error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/touch_adc_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module touch_adc_model (
	input  logic touch_clk,
	input  logic touch_csb,
	input  logic data_out,
	input  logic hold_busy,
	output logic data_in,
	output logic touch_busy
);
	import touch_pkg::*;

	localparam int MAX_CMDS = 256;
	localparam int STIM_ROWS = 4;

	logic [RESULT_BITS-1:0] stim [0:STIM_ROWS*16-1];
	logic [CMD_BITS-1:0] cmd_log [0:MAX_CMDS-1];
	int cmd_count;
	int axis_count [0:2];
	int seed;

	initial begin
		logic [CMD_BITS-1:0] cmd;
		logic [RESULT_BITS-1:0] value;
		int axis;
		int busy_periods;
		int i;
		$readmemh("verif/touch_stim.txt", stim);
		seed = 32'hb934;
		data_in = 1'b0;
		touch_busy = 1'b0;
		cmd = '0;
		cmd_count = 0;
		axis_count[0] = 0;
		axis_count[1] = 0;
		axis_count[2] = 0;
		forever begin
			@(negedge touch_csb);
			// Command comes in MSB first on rising edges
			for (i = 0; i < CMD_BITS; i++) begin
				@(posedge touch_clk);
				cmd = {cmd[CMD_BITS-2:0], data_out};
			end
			if (cmd_count < MAX_CMDS) begin
				cmd_log[cmd_count] = cmd;
			end
			cmd_count++;
			case (cmd[6:4])
				3'b101: axis = 0;
				3'b001: axis = 1;
				default: axis = 2;
			endcase
			// Row wraps once the stim data runs out
			value = stim[((axis_count[axis] / 4) % STIM_ROWS) * 16 + axis * 4
				+ axis_count[axis] % 4];
			axis_count[axis]++;
			@(negedge touch_clk);
			touch_busy <= 1'b1;
			if (hold_busy) begin
				@(posedge touch_csb);
				touch_busy <= 1'b0;
			end else begin
				busy_periods = 1 + ($unsigned($random(seed)) % 3);
				repeat (busy_periods) @(negedge touch_clk);
				touch_busy <= 1'b0;
				// Link needs one more period to see busy low
				@(negedge touch_clk);
				for (i = RESULT_BITS - 1; i >= 0; i--) begin
					data_in <= value[i];
					@(negedge touch_clk);
				end
				data_in <= 1'b0;
				@(posedge touch_csb);
			end
		end
	end

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
	output logic cclk,
	output logic rstb
);
	localparam int RESET_CYCLES = 3;

	// 8 ns period
	initial begin
		cclk = 1'b0;
		forever #4 cclk = ~cclk;
	end

	// Release on a falling edge, like every other input
	initial begin
		rstb = 1'b0;
		repeat (RESET_CYCLES) @(posedge cclk);
		@(negedge cclk);
		rstb = 1'b1;
	end

endmodule

`default_nettype wire

// ==== design/touchpad_controller.sv ====
`timescale 1ns/100ps
`default_nettype none

module touchpad_controller (
	input  logic                                   cclk,
	input  logic                                   rstb,
	output logic                                   touch_clk,
	output logic                                   touch_csb,
	output logic                                   data_out,
	input  logic                                   data_in,
	input  logic                                   touch_busy,
	input  logic [touch_pkg::AXIL_ADDR_BITS-1:0]   axil_awaddr,
	input  logic                                   axil_awvalid,
	output logic                                   axil_awready,
	input  logic [31:0]                            axil_wdata,
	input  logic [3:0]                             axil_wstrb,
	input  logic                                   axil_wvalid,
	output logic                                   axil_wready,
	output logic [1:0]                             axil_bresp,
	output logic                                   axil_bvalid,
	input  logic                                   axil_bready,
	input  logic [touch_pkg::AXIL_ADDR_BITS-1:0]   axil_araddr,
	input  logic                                   axil_arvalid,
	output logic                                   axil_arready,
	output logic [31:0]                            axil_rdata,
	output logic [1:0]                             axil_rresp,
	output logic                                   axil_rvalid,
	input  logic                                   axil_rready
);
	import touch_pkg::*;

	// Engine to link
	logic conv_start;
	logic [CMD_BITS-1:0] cmd_byte;
	logic conv_done;
	logic [RESULT_BITS-1:0] conv_result;
	logic conv_timeout;

	// Engine to register file
	logic scan_enable;
	logic frame_valid;
	logic [RESULT_BITS-1:0] frame_x;
	logic [RESULT_BITS-1:0] frame_y;
	logic [RESULT_BITS-1:0] frame_z;
	logic frame_pen;

	// Port names match the wires above
	touch_serial_link i_touch_serial_link (.*);

	touch_scan_engine i_touch_scan_engine (.*);

	touch_axil_regs i_touch_axil_regs (.*);

endmodule

`default_nettype wire

// ==== design/touch_axil_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module touch_axil_regs (
	input  logic                                   cclk,
	input  logic                                   rstb,
	input  logic [touch_pkg::AXIL_ADDR_BITS-1:0]   axil_awaddr,
	input  logic                                   axil_awvalid,
	output logic                                   axil_awready,
	input  logic [31:0]                            axil_wdata,
	input  logic [3:0]                             axil_wstrb,
	input  logic                                   axil_wvalid,
	output logic                                   axil_wready,
	output logic [1:0]                             axil_bresp,
	output logic                                   axil_bvalid,
	input  logic                                   axil_bready,
	input  logic [touch_pkg::AXIL_ADDR_BITS-1:0]   axil_araddr,
	input  logic                                   axil_arvalid,
	output logic                                   axil_arready,
	output logic [31:0]                            axil_rdata,
	output logic [1:0]                             axil_rresp,
	output logic                                   axil_rvalid,
	input  logic                                   axil_rready,
	input  logic                                   frame_valid,
	input  logic [touch_pkg::RESULT_BITS-1:0]      frame_x,
	input  logic [touch_pkg::RESULT_BITS-1:0]      frame_y,
	input  logic [touch_pkg::RESULT_BITS-1:0]      frame_z,
	input  logic                                   frame_pen,
	output logic                                   scan_enable
);
	import touch_pkg::*;

	logic [RESULT_BITS-1:0] x_reg;
	logic [RESULT_BITS-1:0] y_reg;
	logic [RESULT_BITS-1:0] z_reg;
	logic [15:0] frame_count;
	logic pen_reg;
	logic wr_fire;
	logic rd_fire;
	logic rd_hit;
	logic [31:0] rd_data;

	assign wr_fire = axil_awready && axil_awvalid && axil_wvalid;
	assign rd_fire = axil_arready && axil_arvalid;

	// Whole frame lands in one cycle so X, Y and Z always match
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			x_reg <= '0;
			y_reg <= '0;
			z_reg <= '0;
			pen_reg <= 1'b0;
			frame_count <= '0;
		end else if (frame_valid) begin
			x_reg <= frame_x;
			y_reg <= frame_y;
			z_reg <= frame_z;
			pen_reg <= frame_pen;
			frame_count <= frame_count + 1'b1;
		end
	end

	// Write path, address and data taken together
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			axil_awready <= 1'b0;
			axil_wready <= 1'b0;
			axil_bvalid <= 1'b0;
			axil_bresp <= RESP_OKAY;
			scan_enable <= 1'b0;
		end else begin
			axil_awready <= 1'b0;
			axil_wready <= 1'b0;
			if (axil_awvalid && axil_wvalid && !axil_awready && !axil_bvalid) begin
				axil_awready <= 1'b1;
				axil_wready <= 1'b1;
			end
			if (wr_fire) begin
				axil_bvalid <= 1'b1;
				// CTRL is the only writable register
				if (axil_awaddr == REG_CTRL) begin
					axil_bresp <= RESP_OKAY;
					if (axil_wstrb[0]) begin
						scan_enable <= axil_wdata[0];
					end
				end else begin
					axil_bresp <= RESP_SLVERR;
				end
			end else if (axil_bvalid && axil_bready) begin
				axil_bvalid <= 1'b0;
			end
		end
	end

	always_comb begin
		rd_hit = 1'b1;
		rd_data = '0;
		case (axil_araddr)
			REG_X: rd_data = {{(32 - RESULT_BITS){1'b0}}, x_reg};
			REG_Y: rd_data = {{(32 - RESULT_BITS){1'b0}}, y_reg};
			REG_Z: rd_data = {{(32 - RESULT_BITS){1'b0}}, z_reg};
			REG_STATUS: rd_data = {frame_count, 15'b0, pen_reg};
			REG_CTRL: rd_data = {31'b0, scan_enable};
			default: rd_hit = 1'b0;
		endcase
	end

	// Read path, data captured once at the address handshake
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			axil_arready <= 1'b0;
			axil_rvalid <= 1'b0;
			axil_rdata <= '0;
			axil_rresp <= RESP_OKAY;
		end else begin
			axil_arready <= 1'b0;
			if (axil_arvalid && !axil_arready && !axil_rvalid) begin
				axil_arready <= 1'b1;
			end
			if (rd_fire) begin
				axil_rvalid <= 1'b1;
				axil_rdata <= rd_data;
				axil_rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
			end else if (axil_rvalid && axil_rready) begin
				axil_rvalid <= 1'b0;
			end
		end
	end

	// New frames must not disturb a read that is being held off
	assert property (@(posedge cclk) disable iff (!rstb)
		axil_rvalid && !axil_rready |=> $stable(axil_rdata));

endmodule

`default_nettype wire

// ==== design/touch_scan_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module touch_scan_engine (
	input  logic                                cclk,
	input  logic                                rstb,
	input  logic                                scan_enable,
	input  logic                                conv_done,
	input  logic [touch_pkg::RESULT_BITS-1:0]   conv_result,
	input  logic                                conv_timeout,
	output logic                                conv_start,
	output logic [touch_pkg::CMD_BITS-1:0]      cmd_byte,
	output logic                                frame_valid,
	output logic [touch_pkg::RESULT_BITS-1:0]   frame_x,
	output logic [touch_pkg::RESULT_BITS-1:0]   frame_y,
	output logic [touch_pkg::RESULT_BITS-1:0]   frame_z,
	output logic                                frame_pen
);
	import touch_pkg::*;

	localparam int CNT_BITS = $clog2(SAMPLES_PER_AXIS);
	localparam int ACC_BITS = RESULT_BITS + CNT_BITS;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT,
		ST_FRAME
	} scan_state_t;

	scan_state_t state;
	logic [1:0] axis;
	logic [CNT_BITS-1:0] sample_cnt;
	logic [ACC_BITS-1:0] acc;
	logic [ACC_BITS-1:0] acc_next;
	logic [RESULT_BITS-1:0] avg_next;
	logic [RESULT_BITS-1:0] avg_x;
	logic [RESULT_BITS-1:0] avg_y;
	logic [RESULT_BITS-1:0] avg_z;
	logic frame_err;
	logic last_sample;

	// Offset removal with clamp at both ends
	function automatic logic [RESULT_BITS-1:0] calibrate(
		input logic [RESULT_BITS-1:0] avg,
		input logic [RESULT_BITS-1:0] adj_min,
		input logic [RESULT_BITS-1:0] post_max
	);
		logic [RESULT_BITS-1:0] diff;
		diff = avg - adj_min;
		if (avg < adj_min) begin
			return '0;
		end
		return (diff > post_max) ? post_max : diff;
	endfunction

	always_comb begin
		case (axis)
			AXIS_X: cmd_byte = CMD_X;
			AXIS_Y: cmd_byte = CMD_Y;
			default: cmd_byte = CMD_Z;
		endcase
	end

	assign acc_next = acc + ACC_BITS'(conv_result);
	// Divide by the sample count, remainder dropped
	assign avg_next = acc_next[ACC_BITS-1:CNT_BITS];
	assign last_sample = (sample_cnt == CNT_BITS'(SAMPLES_PER_AXIS - 1));

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			state <= ST_IDLE;
			axis <= AXIS_X;
			sample_cnt <= '0;
			acc <= '0;
			frame_err <= 1'b0;
			conv_start <= 1'b0;
			frame_valid <= 1'b0;
		end else begin
			conv_start <= 1'b0;
			frame_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					// Stopping only takes effect between conversions
					if (scan_enable) begin
						conv_start <= 1'b1;
						state <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (conv_done) begin
						state <= ST_IDLE;
						if (conv_timeout) begin
							frame_err <= 1'b1;
						end
						if (last_sample) begin
							acc <= '0;
							sample_cnt <= '0;
							if (axis == AXIS_Z) begin
								axis <= AXIS_X;
								state <= ST_FRAME;
							end else begin
								axis <= axis + 1'b1;
							end
						end else begin
							acc <= acc_next;
							sample_cnt <= sample_cnt + 1'b1;
						end
					end
				end
				ST_FRAME: begin
					frame_valid <= 1'b1;
					frame_err <= 1'b0;
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge cclk) begin
		if (state == ST_WAIT && conv_done && last_sample) begin
			case (axis)
				AXIS_X: avg_x <= avg_next;
				AXIS_Y: avg_y <= avg_next;
				default: avg_z <= avg_next;
			endcase
		end
		if (state == ST_FRAME) begin
			frame_x <= frame_err ? '0 : calibrate(avg_x, X_ADJ_MIN, X_POST_ADJ_MAX);
			frame_y <= frame_err ? '0 : calibrate(avg_y, Y_ADJ_MIN, Y_POST_ADJ_MAX);
			frame_z <= avg_z;
			frame_pen <= !frame_err && (avg_z > Z_PEN_THRESH);
		end
	end

	// Link completes only the single conversion this engine is waiting on
	assert property (@(posedge cclk) disable iff (!rstb)
		conv_done |-> (state == ST_WAIT) && !conv_start);

endmodule

`default_nettype wire

// ==== design/touch_serial_link.sv ====
`timescale 1ns/100ps
`default_nettype none

module touch_serial_link (
	input  logic                                cclk,
	input  logic                                rstb,
	input  logic                                conv_start,
	input  logic [touch_pkg::CMD_BITS-1:0]      cmd_byte,
	input  logic                                data_in,
	input  logic                                touch_busy,
	output logic                                touch_clk,
	output logic                                touch_csb,
	output logic                                data_out,
	output logic                                conv_done,
	output logic [touch_pkg::RESULT_BITS-1:0]   conv_result,
	output logic                                conv_timeout
);
	import touch_pkg::*;

	localparam int DIV_BITS = $clog2(TOUCH_CLK_DIV_COUNT);
	localparam int TRAIL_PERIODS = 3;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CMD,
		ST_BUSY,
		ST_RECV,
		ST_TRAIL
	} link_state_t;

	link_state_t state;
	logic [DIV_BITS-1:0] div_cnt;
	logic [3:0] period_cnt;
	logic [CMD_BITS-1:0] cmd_shift;
	logic [RESULT_BITS-1:0] rx_shift;
	logic busy_sample;
	logic timed_out;
	logic div_wrap;
	logic rise_tick;
	logic fall_tick;
	logic trail_end;

	// One toggle of touch_clk per wrap; a period ends on the falling edge
	assign div_wrap = (div_cnt == DIV_BITS'(TOUCH_CLK_DIV_COUNT - 1));
	assign rise_tick = div_wrap && !touch_clk;
	assign fall_tick = div_wrap && touch_clk;
	assign trail_end = (state == ST_TRAIL) && fall_tick &&
		(period_cnt == 4'(TRAIL_PERIODS - 1));

	// Divider parks with touch_clk low whenever the link is idle
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			div_cnt <= '0;
			touch_clk <= 1'b0;
		end else if (state == ST_IDLE) begin
			div_cnt <= '0;
			touch_clk <= 1'b0;
		end else if (div_wrap) begin
			div_cnt <= '0;
			touch_clk <= !touch_clk;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			state <= ST_IDLE;
			touch_csb <= 1'b1;
			data_out <= 1'b0;
			period_cnt <= '0;
			timed_out <= 1'b0;
			conv_done <= 1'b0;
			conv_timeout <= 1'b0;
		end else begin
			conv_done <= 1'b0;
			conv_timeout <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (conv_start) begin
						// MSB goes out ahead of the first rising edge
						state <= ST_CMD;
						touch_csb <= 1'b0;
						data_out <= cmd_byte[CMD_BITS-1];
						period_cnt <= '0;
						timed_out <= 1'b0;
					end
				end
				ST_CMD: begin
					if (fall_tick) begin
						data_out <= cmd_shift[CMD_BITS-1];
						period_cnt <= period_cnt + 1'b1;
						if (period_cnt == 4'(CMD_BITS - 1)) begin
							state <= ST_BUSY;
							period_cnt <= '0;
						end
					end
				end
				ST_BUSY: begin
					if (fall_tick) begin
						period_cnt <= period_cnt + 1'b1;
						if (!busy_sample) begin
							state <= ST_RECV;
							period_cnt <= '0;
						end else if (period_cnt == 4'(BUSY_TIMEOUT - 1)) begin
							state <= ST_TRAIL;
							period_cnt <= '0;
							timed_out <= 1'b1;
						end
					end
				end
				ST_RECV: begin
					if (fall_tick) begin
						period_cnt <= period_cnt + 1'b1;
						if (period_cnt == 4'(RESULT_BITS - 1)) begin
							state <= ST_TRAIL;
							period_cnt <= '0;
						end
					end
				end
				ST_TRAIL: begin
					if (fall_tick) begin
						period_cnt <= period_cnt + 1'b1;
					end
					if (trail_end) begin
						state <= ST_IDLE;
						touch_csb <= 1'b1;
						conv_done <= 1'b1;
						conv_timeout <= timed_out;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Shift registers, busy sample and result
	always_ff @(posedge cclk) begin
		if (state == ST_IDLE && conv_start) begin
			cmd_shift <= {cmd_byte[CMD_BITS-2:0], 1'b0};
		end else if (state == ST_CMD && fall_tick) begin
			cmd_shift <= cmd_shift << 1;
		end
		if (rise_tick) begin
			busy_sample <= touch_busy;
		end
		if (state == ST_RECV && rise_tick) begin
			rx_shift <= {rx_shift[RESULT_BITS-2:0], data_in};
		end
		if (trail_end) begin
			conv_result <= timed_out ? '0 : rx_shift;
		end
	end

	// Scan engine must wait for conv_done before starting again
	assert property (@(posedge cclk) disable iff (!rstb)
		conv_start |-> state == ST_IDLE);

	// Chip select low from the first command bit to the last
	assert property (@(posedge cclk) disable iff (!rstb)
		(state == ST_CMD) |-> !touch_csb);

endmodule

`default_nettype wire

// ==== design/touch_pkg.sv ====
`default_nettype none

package touch_pkg;

	// Serial link to the converter
	localparam int TOUCH_CLK_DIV_COUNT = 25;
	localparam int CMD_BITS = 8;
	localparam int RESULT_BITS = 12;
	localparam int BUSY_TIMEOUT = 8;

	// Axis selectors, scanned in this order
	localparam logic [1:0] AXIS_X = 2'd0;
	localparam logic [1:0] AXIS_Y = 2'd1;
	localparam logic [1:0] AXIS_Z = 2'd2;

	// Start, channel A2..A0, mode 0 = 12 bit, SER = 1, PD1..PD0 = 00
	localparam logic [CMD_BITS-1:0] CMD_X = 8'b1_101_0_1_00;
	localparam logic [CMD_BITS-1:0] CMD_Y = 8'b1_001_0_1_00;
	localparam logic [CMD_BITS-1:0] CMD_Z = 8'b1_011_0_1_00;

	localparam int SAMPLES_PER_AXIS = 4;

	// Fixed calibration window
	localparam logic [RESULT_BITS-1:0] X_ADJ_MIN = 12'h096;
	localparam logic [RESULT_BITS-1:0] X_POST_ADJ_MAX = 12'hF6E;
	localparam logic [RESULT_BITS-1:0] Y_ADJ_MIN = 12'h12C;
	localparam logic [RESULT_BITS-1:0] Y_POST_ADJ_MAX = 12'hED8;

	// Pen counts as down strictly above this pressure value
	localparam logic [RESULT_BITS-1:0] Z_PEN_THRESH = 12'h100;

	// Register map
	localparam int AXIL_ADDR_BITS = 5;
	localparam logic [AXIL_ADDR_BITS-1:0] REG_X = 5'h00;
	localparam logic [AXIL_ADDR_BITS-1:0] REG_Y = 5'h04;
	localparam logic [AXIL_ADDR_BITS-1:0] REG_Z = 5'h08;
	localparam logic [AXIL_ADDR_BITS-1:0] REG_STATUS = 5'h0C;
	localparam logic [AXIL_ADDR_BITS-1:0] REG_CTRL = 5'h10;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire
